// File: bench/scope_checker.sv
module scope_checker import scope_pkg::*; (
   input  logic             adc_clk,
   input  logic [ADC_W-1:0] adc_data_i,
   input  logic             ext_trigger_i,
   input  logic             cmd_valid_i,
   input  scope_op_e        cmd_op_i,
   input  logic [31:0]      cmd_data_i,
   input  logic             arm_o,
   input  logic             armed_o,
   input  logic             capture_go_o,
   input  logic             capture_done_o,
   input  logic             rd_valid_o,
   input  logic [31:0]      rd_data_o,
   input  int               test_id_i,
   input  int               timeouts_i,      // running timeout count
   input  logic             test_start_i,    // strobes from the testbench
   input  logic             test_end_i,
   input  logic             check_idle_i,
   input  logic             summary_i,
   input  logic             source_i,        // current row config
   input  logic             pol_i,
   input  logic             wait_i,
   input  logic [ADC_W-1:0] level_i,
   input  logic [31:0]      offset_i,
   input  logic [6:0]       nsamp_i,
   output int               fail_tests_o,
   output int               pass_tests_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic             trig_active;  // model of the qualified trigger
   logic             armed_prev;   // armed_o seen by the coming edge
   logic             fired;
   logic             force_pend;   // force reaches the trigger one edge later
   logic [ADC_W-1:0] fire_val;     // ramp value at the firing edge
   logic [ADC_W-1:0] exp_sample;
   logic [1:0]       arm_age;      // 0 arm edge, 1 length clear, 2 counting
   int               len_cnt;
   int               len_exp;
   int               rd_idx;
   int               test_errors;
   int               timeouts_start;  // timeouts before this test

   initial begin
      fail_tests_o   = 0;
      pass_tests_o   = 0;
      armed_prev     = 1'b0;
      fired          = 1'b0;
      force_pend     = 1'b0;
      arm_age        = 2'd2;
      len_cnt        = 0;
      len_exp        = 0;
      rd_idx         = 0;
      test_errors    = 0;
      timeouts_start = 0;
   end

   task automatic report_error(input string msg);
      $display("FAILED at %0d ns: test %0d %s", $time, test_id_i, msg);
      test_errors++;
   endtask

   // sample mid high phase where outputs and inputs have both settled
   always @(posedge adc_clk) begin
      #10;
      trig_active = (source_i ? (adc_data_i > level_i) : ext_trigger_i) == pol_i;
      if (test_start_i) begin
         fired          = 1'b0;
         force_pend     = 1'b0;
         rd_idx         = 0;
         test_errors    = 0;
         timeouts_start = timeouts_i;
      end
      if (!fired && ((armed_prev && trig_active) || force_pend)) begin
         fired    = 1'b1;       // first firing edge of this arm
         fire_val = adc_data_i;
      end
      force_pend = cmd_valid_i && (cmd_op_i == OP_FORCE);
      // armed must not rise on an active trigger when wait is set
      if (wait_i && armed_o && !armed_prev && trig_active)
         report_error("armed rose while trigger still active");
      armed_prev = armed_o;
      // trigger length counted from the edge after arm level rises
      if (cmd_valid_i && (cmd_op_i == OP_ARM)) begin
         arm_age = 2'd0;
         len_cnt = 0;
      end else if (arm_age == 2'd0) begin
         arm_age = 2'd1;
         len_cnt = 0;
         if (!arm_o)
            report_error("arm_o did not rise the cycle after the arm level");
      end else begin
         arm_age = 2'd2;
         if (trig_active) len_cnt++;
      end
      if (cmd_valid_i && (cmd_op_i == OP_READ) && cmd_data_i[7])
         len_exp = len_cnt;
      if (rd_valid_o) begin
         if (rd_idx < int'(nsamp_i)) begin
            exp_sample = fire_val + 12'd2 + offset_i[ADC_W-1:0] + ADC_W'(rd_idx);
            if (!fired)
               report_error($sformatf("sample %0d read without a trigger", rd_idx));
            else if (rd_data_o !== {20'd0, exp_sample})
               report_error($sformatf("sample %0d got %0d expected %0d",
                                      rd_idx, rd_data_o, exp_sample));
         end else if (rd_data_o !== 32'(len_exp)) begin
            report_error($sformatf("trigger length got %0d expected %0d",
                                   rd_data_o, len_exp));
         end
         rd_idx++;
      end
      if (check_idle_i && (arm_o || armed_o || capture_go_o || capture_done_o))
         report_error($sformatf("status not idle arm %b armed %b go %b done %b",
                                arm_o, armed_o, capture_go_o, capture_done_o));
      if (test_end_i) begin
         if (test_errors == 0 && timeouts_i == timeouts_start) begin
            $display("test %0d passed", test_id_i);
            pass_tests_o++;
         end else begin
            $display("test %0d failed with %0d errors and %0d timeouts", test_id_i,
                     test_errors, timeouts_i - timeouts_start);
            fail_tests_o++;
         end
      end
      if (summary_i)
         $display("tests run %0d, passed %0d, failed %0d",
                  pass_tests_o + fail_tests_o, pass_tests_o, fail_tests_o);
   end

endmodule

// File: bench/scope_tb.sv
module scope_tb import scope_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic        source;      // 1 adc compare
      logic        pol;
      logic        wait_in;     // also holds the pin active across ARM
      logic [11:0] level;
      logic [31:0] offset;
      logic [6:0]  nsamp;
      logic        force_trig;
      logic [7:0]  pulse;       // ext pulse cycles drawn from the lfsr when 0
   } row_t;

   localparam int NUM_ROWS = 7;
   localparam int WAIT_MAX = 6000;  // longer than one 4096 cycle ramp period

   logic             adc_clk;
   logic             reset;
   logic [ADC_W-1:0] adc_data_i;
   logic             ext_trigger_i;
   logic             cmd_valid_i;
   scope_op_e        cmd_op_i;
   logic [31:0]      cmd_data_i;
   logic             arm_o, armed_o, capture_go_o, capture_done_o;
   logic             rd_valid_o;
   logic [31:0]      rd_data_o;
   logic             test_start, test_end, check_idle, summary;
   int               test_id;
   int               fail_tests, pass_tests;
   int               timeouts;
   row_t             rows [NUM_ROWS];
   row_t             cur;
   logic [15:0]      lfsr;

   scope_top DUT (.*);

   scope_checker u_checker (
      .adc_clk, .adc_data_i, .ext_trigger_i, .cmd_valid_i, .cmd_op_i, .cmd_data_i,
      .arm_o, .armed_o, .capture_go_o, .capture_done_o, .rd_valid_o, .rd_data_o,
      .test_id_i(test_id), .timeouts_i(timeouts),
      .test_start_i(test_start), .test_end_i(test_end),
      .check_idle_i(check_idle), .summary_i(summary),
      .source_i(cur.source), .pol_i(cur.pol), .wait_i(cur.wait_in),
      .level_i(cur.level), .offset_i(cur.offset), .nsamp_i(cur.nsamp),
      .fail_tests_o(fail_tests), .pass_tests_o(pass_tests)
   );

   initial begin
      adc_clk = 1'b0;
      forever #50 adc_clk = ~adc_clk;  // 100 ns period
   end

   // free running ramp wrapping at 4095
   initial begin
      adc_data_i = '0;
      forever begin
         @(negedge adc_clk);
         adc_data_i = adc_data_i + 1'b1;
      end
   end

   // fibonacci lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);   // one step per bit
         val  = {val[6:0], lfsr[0]};
      end
      return val;
   endfunction

   task automatic send_cmd(input scope_op_e op, input logic [31:0] data);
      cmd_valid_i = 1'b1;
      cmd_op_i    = op;
      cmd_data_i  = data;
      @(negedge adc_clk);
      cmd_valid_i = 1'b0;
   endtask

   task automatic strobe(input int which);
      case (which)
         0: test_start = 1'b1;
         1: test_end   = 1'b1;
         2: check_idle = 1'b1;
         default: summary = 1'b1;
      endcase
      @(negedge adc_clk);
      {test_start, test_end, check_idle, summary} = '0;
   endtask

   // which 0 armed_o, 1 capture_done_o, 2 rd_valid_o
   task automatic wait_high(input int which, input int limit, input string what);
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < limit && !seen; i++) begin
         @(negedge adc_clk);
         seen = (which == 0) ? armed_o : (which == 1) ? capture_done_o : rd_valid_o;
      end
      if (!seen) begin
         $display("timeout in test %0d while waiting for %s", test_id, what);
         timeouts++;
      end
   endtask

   task automatic run_row(input row_t r);
      cur           = r;
      ext_trigger_i = ~r.pol;                   // pin idles inactive
      strobe(0);
      send_cmd(OP_CFG, {29'd0, r.wait_in, r.pol, r.source});
      send_cmd(OP_LEVEL, {20'd0, r.level});
      send_cmd(OP_OFFSET, r.offset);
      send_cmd(OP_NSAMP, {25'd0, r.nsamp});
      if (!r.source && r.wait_in) ext_trigger_i = r.pol;
      send_cmd(OP_ARM, 32'd0);
      if (!r.source) begin
         if (r.wait_in) begin
            repeat (4) @(negedge adc_clk);      // armed must stay low here
            ext_trigger_i = ~r.pol;
         end
         wait_high(0, 20, "armed");
         repeat (3) @(negedge adc_clk);
         if (r.force_trig) begin
            send_cmd(OP_FORCE, 32'd0);
         end else begin
            ext_trigger_i = r.pol;
            repeat (r.pulse) @(negedge adc_clk);
            ext_trigger_i = ~r.pol;
         end
      end
      wait_high(1, WAIT_MAX, "capture done");
      for (int k = 0; k < int'(r.nsamp); k++) begin
         send_cmd(OP_READ, 32'(k));
         wait_high(2, 4, "sample readback");
      end
      send_cmd(OP_READ, 32'h80);
      wait_high(2, 4, "length readback");
      send_cmd(OP_DISARM, 32'd0);
      repeat (3) @(negedge adc_clk);
      strobe(2);
      strobe(1);
   endtask

   initial begin
      reset         = 1'b1;
      ext_trigger_i = 1'b0;
      cmd_valid_i   = 1'b0;
      cmd_op_i      = OP_CFG;
      cmd_data_i    = '0;
      {test_start, test_end, check_idle, summary} = '0;
      test_id       = 0;
      timeouts      = 0;
      lfsr          = 16'd10;
      cur           = '0;
      // src pol wait level offset nsamp force pulse
      rows[0] = '{1'b1, 1'b1, 1'b0, 12'd100,  32'd0, 7'd8,  1'b0, 8'd0};
      rows[1] = '{1'b1, 1'b1, 1'b0, 12'd2000, 32'd5, 7'd16, 1'b0, 8'd0};
      rows[2] = '{1'b0, 1'b1, 1'b1, 12'd0,    32'd0, 7'd4,  1'b0, 8'd0};
      rows[3] = '{1'b0, 1'b0, 1'b0, 12'd0,    32'd3, 7'd6,  1'b0, 8'd0};
      rows[4] = '{1'b0, 1'b1, 1'b0, 12'd0,    32'd2, 7'd5,  1'b1, 8'd0};
      rows[5] = '{1'b0, 1'b1, 1'b0, 12'd0,    32'd0, 7'd64, 1'b0, 8'd0};
      rows[6] = '{1'b1, 1'b1, 1'b0, 12'd4000, 32'd1, 7'd1,  1'b0, 8'd0};
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (!rows[i].source && !rows[i].force_trig)
            rows[i].pulse = 8'd2 + take_bits(4);
      end
      repeat (10) @(negedge adc_clk);
      reset = 1'b0;
      strobe(0);                                 // test 0 is the reset state
      strobe(2);
      strobe(1);
      for (int i = 0; i < NUM_ROWS; i++) begin
         test_id = i + 1;
         run_row(rows[i]);
      end
      strobe(3);
      @(negedge adc_clk);
      if (fail_tests == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: logic/scope_capture_buffer.sv
module scope_capture_buffer import scope_pkg::*; (
   input  logic             adc_clk,
   input  logic             reset,
   input  logic [ADC_W-1:0] adc_data_i,      // sample to store
   input  scope_cfg_t       cfg_i,           // nsamp used here
   input  logic             capture_go_i,    // delayed capture request
   input  logic             arm_level_i,     // low returns fsm to idle
   input  read_req_t        read_req_i,      // readback request
   input  logic [CNT_W-1:0] trig_length_i,   // for length readback
   output logic             buf_ready_o,     // idle, may arm
   output logic             capture_done_o,  // held while full
   output logic             rd_valid_o,      // one cycle after request
   output logic [31:0]      rd_data_o
);

   logic [ADC_W-1:0]  mem [BUF_DEPTH];  // sample memory
   cap_state_e        state;
   logic [ADDR_W-1:0] wr_ptr;           // next write address
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic              last_wr;          // this write fills nsamp

   // first write happens in idle at address 0
   assign wr_en   = ((state == CAP_IDLE) & capture_go_i) | (state == CAP_RECORD);
   assign wr_addr = (state == CAP_IDLE) ? '0 : wr_ptr;
   assign last_wr = ({1'b0, wr_addr} == cfg_i.nsamp - 1'b1);

   assign buf_ready_o    = state == CAP_IDLE;
   assign capture_done_o = state == CAP_DONE;

   // capture fsm
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         state  <= CAP_IDLE;
         wr_ptr <= '0;
      end else begin
         case (state)
            CAP_IDLE: begin
               if (capture_go_i) begin
                  wr_ptr <= ADDR_W'(1);  // sample 0 written now
                  state  <= last_wr ? CAP_DONE : CAP_RECORD;  // nsamp of 1
               end
            end
            CAP_RECORD: begin
               wr_ptr <= wr_ptr + 1'b1;
               if (last_wr) begin
                  state <= CAP_DONE;
               end
            end
            CAP_DONE: begin
               if (~arm_level_i) begin
                  state  <= CAP_IDLE;  // ready for next arm
                  wr_ptr <= '0;
               end
            end
            default: state <= CAP_IDLE;
         endcase
      end
   end

   // sample store
   always_ff @(posedge adc_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= adc_data_i;
      end
   end

   // read port, valid pulse tracks request
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= read_req_i.valid;
      end
   end

   // read data mux, zero-extend samples
   always_ff @(posedge adc_clk) begin
      if (read_req_i.valid) begin
         if (read_req_i.sel_len) begin
            rd_data_o <= 32'(trig_length_i);
         end else begin
            rd_data_o <= {{(32 - ADC_W){1'b0}}, mem[read_req_i.addr]};
         end
      end
   end

endmodule

// File: logic/scope_cmd_decode.sv
module scope_cmd_decode import scope_pkg::*; (
   input  logic        adc_clk,
   input  logic        reset,
   input  logic        cmd_valid_i,  // one cycle per command
   input  scope_op_e   cmd_op_i,
   input  logic [31:0] cmd_data_i,
   output scope_cfg_t  cfg_o,        // registered configuration
   output logic        arm_level_o,  // held between ARM and DISARM
   output logic        force_now_o,  // one cycle pulse
   output read_req_t   read_req_o    // one cycle request
);

   logic [NSAMP_W-1:0] nsamp_sat;  // clamped capture length

   // clamp sample count into 1..BUF_DEPTH
   always_comb begin
      if (cmd_data_i == 32'd0) begin
         nsamp_sat = NSAMP_W'(1);  // zero would never finish
      end else if (cmd_data_i > 32'(BUF_DEPTH)) begin
         nsamp_sat = NSAMP_W'(BUF_DEPTH);  // cap at memory size
      end else begin
         nsamp_sat = cmd_data_i[NSAMP_W-1:0];
      end
   end

   // configuration register
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         cfg_o       <= '0;
         cfg_o.nsamp <= NSAMP_W'(BUF_DEPTH);  // default full buffer
      end else if (cmd_valid_i) begin
         case (cmd_op_i)
            OP_CFG: begin
               cfg_o.source        <= cmd_data_i[0];
               cfg_o.level_pol     <= cmd_data_i[1];
               cfg_o.wait_inactive <= cmd_data_i[2];
            end
            OP_LEVEL:  cfg_o.adc_level <= cmd_data_i[ADC_W-1:0];
            OP_OFFSET: cfg_o.offset    <= cmd_data_i[CNT_W-1:0];
            OP_NSAMP:  cfg_o.nsamp     <= nsamp_sat;
            default: ;  // other opcodes leave config alone
         endcase
      end
   end

   // arm level, force and read pulses
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         arm_level_o <= 1'b0;
         force_now_o <= 1'b0;
         read_req_o  <= '0;
      end else begin
         force_now_o      <= 1'b0;  // pulses by default
         read_req_o.valid <= 1'b0;
         if (cmd_valid_i) begin
            case (cmd_op_i)
               OP_ARM:    arm_level_o <= 1'b1;
               OP_DISARM: arm_level_o <= 1'b0;
               OP_FORCE:  force_now_o <= 1'b1;
               OP_READ: begin
                  read_req_o.valid   <= 1'b1;
                  read_req_o.sel_len <= cmd_data_i[7];         // length word
                  read_req_o.addr    <= cmd_data_i[ADDR_W-1:0];  // sample index
               end
               default: ;  // config writes handled above
            endcase
         end
      end
   end

endmodule

// File: logic/scope_pkg.sv
package scope_pkg;

   // sample and buffer geometry
   localparam int ADC_W     = 12;          // adc sample width
   localparam int BUF_DEPTH = 64;          // words in sample memory
   localparam int ADDR_W    = 6;           // log2(BUF_DEPTH)
   localparam int NSAMP_W   = ADDR_W + 1;  // holds 1..BUF_DEPTH
   localparam int CNT_W     = 32;          // offset and trigger length counters

   // command opcodes carried with cmd_valid_i
   typedef enum logic [2:0] {
      OP_CFG    = 3'd0,  // data[0] source, data[1] polarity, data[2] wait
      OP_LEVEL  = 3'd1,  // data[11:0] adc threshold
      OP_OFFSET = 3'd2,  // post-trigger delay in adc cycles
      OP_NSAMP  = 3'd3,  // capture length, saturated to 1..BUF_DEPTH
      OP_ARM    = 3'd4,  // raise arm level
      OP_DISARM = 3'd5,  // drop arm level
      OP_FORCE  = 3'd6,  // trigger now
      OP_READ   = 3'd7   // data[7] length select, data[5:0] sample address
   } scope_op_e;

   // capture buffer fsm
   typedef enum logic [1:0] {
      CAP_IDLE   = 2'd0,  // ready for a trigger
      CAP_RECORD = 2'd1,  // filling memory
      CAP_DONE   = 2'd2   // full, waits for disarm
   } cap_state_e;

   // trigger and capture configuration
   typedef struct packed {
      logic               source;         // 1 internal adc compare, 0 ext pin
      logic               level_pol;      // 1 high/rising, 0 low/falling
      logic               wait_inactive;  // see inactive trigger before arming
      logic [ADC_W-1:0]   adc_level;      // compare threshold
      logic [CNT_W-1:0]   offset;         // cycles from trigger to capture
      logic [NSAMP_W-1:0] nsamp;          // samples per capture
   } scope_cfg_t;

   // readback request toward the capture buffer
   typedef struct packed {
      logic              valid;    // one cycle pulse
      logic              sel_len;  // 1 trigger length, 0 sample word
      logic [ADDR_W-1:0] addr;     // sample address
   } read_req_t;

endpackage

// File: logic/scope_top.sv
module scope_top import scope_pkg::*; (
   input  logic             adc_clk,
   input  logic             reset,
   input  logic [ADC_W-1:0] adc_data_i,      // adc samples
   input  logic             ext_trigger_i,   // external trigger pin
   input  logic             cmd_valid_i,     // command strobe
   input  scope_op_e        cmd_op_i,
   input  logic [31:0]      cmd_data_i,
   output logic             arm_o,           // arm accepted
   output logic             armed_o,         // armed and qualified
   output logic             capture_go_o,    // capture running
   output logic             capture_done_o,  // buffer full
   output logic             rd_valid_o,      // readback pulse
   output logic [31:0]      rd_data_o
);

   scope_cfg_t       cfg;          // decode to trigger and buffer
   read_req_t        read_req;     // decode to buffer
   logic             arm_level;
   logic             force_now;
   logic             buf_ready;    // buffer to trigger
   logic [CNT_W-1:0] trig_length;  // trigger to buffer

   // decode stage
   scope_cmd_decode u_decode (
      .adc_clk     (adc_clk),
      .reset       (reset),
      .cmd_valid_i (cmd_valid_i),
      .cmd_op_i    (cmd_op_i),
      .cmd_data_i  (cmd_data_i),
      .cfg_o       (cfg),
      .arm_level_o (arm_level),
      .force_now_o (force_now),
      .read_req_o  (read_req)
   );

   // execute stage
   scope_trigger_unit u_trigger (
      .adc_clk        (adc_clk),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .ext_trigger_i  (ext_trigger_i),
      .cfg_i          (cfg),
      .arm_level_i    (arm_level),
      .force_now_i    (force_now),
      .buf_ready_i    (buf_ready),
      .capture_done_i (capture_done_o),
      .arm_o          (arm_o),
      .armed_o        (armed_o),
      .capture_go_o   (capture_go_o),
      .trig_length_o  (trig_length)
   );

   // result stage
   scope_capture_buffer u_buffer (
      .adc_clk        (adc_clk),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .cfg_i          (cfg),
      .capture_go_i   (capture_go_o),
      .arm_level_i    (arm_level),
      .read_req_i     (read_req),
      .trig_length_i  (trig_length),
      .buf_ready_o    (buf_ready),
      .capture_done_o (capture_done_o),
      .rd_valid_o     (rd_valid_o),
      .rd_data_o      (rd_data_o)
   );

endmodule

// File: logic/scope_trigger_unit.sv
module scope_trigger_unit import scope_pkg::*; (
   input  logic             adc_clk,
   input  logic             reset,
   input  logic [ADC_W-1:0] adc_data_i,      // current sample
   input  logic             ext_trigger_i,   // external trigger pin
   input  scope_cfg_t       cfg_i,
   input  logic             arm_level_i,     // from decode
   input  logic             force_now_i,     // one cycle force
   input  logic             buf_ready_i,     // capture buffer idle
   input  logic             capture_done_i,  // capture buffer full
   output logic             arm_o,           // arm seen
   output logic             armed_o,         // arm qualified by trigger state
   output logic             capture_go_o,    // delayed by offset
   output logic [CNT_W-1:0] trig_length_o    // active cycles since arm edge
);

   logic             adc_trig;        // threshold compare
   logic             trig_sel;        // chosen trigger source
   logic             trig_active;     // trigger matches polarity
   logic             fire;            // start capture this cycle
   logic             disarm_latch;    // blocks re-arm until disarm
   logic             capture_go_int;  // undelayed capture request
   logic             clear_go;        // drops capture requests
   logic [CNT_W-1:0] delay_cnt;       // cycles since capture_go_int
   logic             arm_level_q;     // arm level one cycle ago
   logic             arm_rise;        // fresh ARM

   assign adc_trig    = adc_data_i > cfg_i.adc_level;
   assign trig_sel    = cfg_i.source ? adc_trig : ext_trigger_i;
   assign trig_active = trig_sel == cfg_i.level_pol;
   assign fire        = (trig_active & armed_o) | force_now_i;
   assign clear_go    = reset | capture_done_i | ~arm_level_i;
   assign arm_rise    = arm_level_i & ~arm_level_q;

   // set on trigger, cleared only once arm drops and capture ends
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         disarm_latch <= 1'b0;
      end else if (fire) begin
         disarm_latch <= 1'b1;
      end else if (~arm_level_i & ~capture_go_int) begin
         disarm_latch <= 1'b0;
      end
   end

   // arm follows the command only
   always_ff @(posedge adc_clk) begin
      if (reset | disarm_latch) begin
         arm_o <= 1'b0;
      end else if (arm_level_i) begin
         arm_o <= 1'b1;
      end
   end

   // armed also needs an idle buffer and, with wait set, an inactive trigger
   always_ff @(posedge adc_clk) begin
      if (reset | disarm_latch) begin
         armed_o <= 1'b0;
      end else if (arm_level_i & buf_ready_i &
                   (~trig_active | ~cfg_i.wait_inactive)) begin
         armed_o <= 1'b1;
      end
   end

   // capture request, held until done or disarm
   always_ff @(posedge adc_clk) begin
      if (clear_go) begin
         capture_go_int <= 1'b0;
      end else if (fire) begin
         capture_go_int <= 1'b1;
      end
   end

   // counts from the cycle capture_go_int is seen
   always_ff @(posedge adc_clk) begin
      if (reset | ~capture_go_int) begin
         delay_cnt <= '0;
      end else begin
         delay_cnt <= delay_cnt + 1'b1;
      end
   end

   // goes high offset+1 cycles after capture_go_int
   always_ff @(posedge adc_clk) begin
      if (clear_go | ~capture_go_int) begin
         capture_go_o <= 1'b0;
      end else if (delay_cnt == cfg_i.offset) begin
         capture_go_o <= 1'b1;  // sticky until cleared
      end
   end

   // arm edge detect for the length counter
   always_ff @(posedge adc_clk) begin
      if (reset) begin
         arm_level_q <= 1'b0;
      end else begin
         arm_level_q <= arm_level_i;
      end
   end

   // trigger length, no handling of repeated toggles
   always_ff @(posedge adc_clk) begin
      if (reset | arm_rise) begin
         trig_length_o <= '0;  // restart on each ARM
      end else if (trig_active) begin
         trig_length_o <= trig_length_o + 1'b1;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the scope capture testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   --top-module scope_tb -f tb.f --Mdir obj_dir -o scope_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see build.log"
   exit 1
fi

./obj_dir/scope_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "simulation exited with an error, see sim.log"
   exit 1
fi
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

// File: tb.f
logic/scope_pkg.sv
logic/scope_cmd_decode.sv
logic/scope_trigger_unit.sv
logic/scope_capture_buffer.sv
logic/scope_top.sv
bench/scope_checker.sv
bench/scope_tb.sv
